/* sources.f */
+incdir+tests
hw/cce_cfg_pkg.sv
hw/cce_inst_pkg.sv
hw/cce_inst_ram.sv
hw/cce_pc.sv
hw/cce_decode.sv
hw/cce_exec.sv
hw/cce_top.sv
tests/tb_cce_top.sv

/* Bender.yml */
package:
  name: cce_ctrl

sources:
  - hw/cce_cfg_pkg.sv
  - hw/cce_inst_pkg.sv
  - hw/cce_inst_ram.sv
  - hw/cce_pc.sv
  - hw/cce_decode.sv
  - hw/cce_exec.sv
  - hw/cce_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cce_top.sv

/* tests/tb_cce_programs.svh */
// program table with instruction words, event_i rise cycle and expected writeback trace per entry

localparam int num_progs_lp = 5;

// fills rom_mem, exp_q, event_cycle and wait_pos for one table entry
task automatic load_program(input int prog);
  int a;
  for (a = 0; a < inst_ram_els_lp; a++) begin
    rom_mem[a] = {OP_NOP, 16'h0000};
  end
  word_cnt = 0;
  exp_q.delete();
  // no event and no WAIT gate unless the entry sets them
  event_cycle = -1;
  wait_pos = 1000;
  case (prog)
    // moves, adds with wrap, back-to-back dependent adds, r3 read straight from reset
    0: begin
      put_word(movi_word(2'd0, 8'h05));
      put_word(addi_word(2'd1, 2'd0, 8'h10));
      put_word(addi_word(2'd1, 2'd1, 8'hf0));
      put_word(addi_word(2'd2, 2'd1, 8'hff));
      put_word(addi_word(2'd3, 2'd3, 8'h01));
      expect_wb(2'd0, 8'h05);
      expect_wb(2'd1, 8'h15);
      expect_wb(2'd1, 8'h05);
      expect_wb(2'd2, 8'h04);
      expect_wb(2'd3, 8'h01);
    end
    // beq taken/not taken, bne taken/not taken, bi, each skip writes 0xee
    1: begin
      put_word(movi_word(2'd0, 8'h07));
      put_word(movi_word(2'd1, 8'h07));
      put_word(branch_word(OP_BEQ, 2'd0, 2'd1, 5'd4));
      put_word(movi_word(2'd2, 8'hee));
      put_word(branch_word(OP_BNE, 2'd0, 2'd1, 5'd6));
      put_word(movi_word(2'd2, 8'h11));
      put_word(branch_word(OP_BNE, 2'd0, 2'd2, 5'd8));
      put_word(movi_word(2'd3, 8'hee));
      put_word(branch_word(OP_BEQ, 2'd0, 2'd2, 5'd10));
      put_word(movi_word(2'd3, 8'h22));
      put_word(branch_word(OP_BI, 2'd0, 2'd0, 5'd12));
      put_word(movi_word(2'd3, 8'hee));
      put_word(movi_word(2'd0, 8'h33));
      expect_wb(2'd0, 8'h07);
      expect_wb(2'd1, 8'h07);
      expect_wb(2'd2, 8'h11);
      expect_wb(2'd3, 8'h22);
      expect_wb(2'd0, 8'h33);
    end
    // WAIT holds until event_i rises at cycle 60, trace entry 1 onward must follow it
    2: begin
      put_word(movi_word(2'd0, 8'h01));
      put_word({OP_WAIT, 16'h0000});
      put_word(addi_word(2'd0, 2'd0, 8'h01));
      put_word(movi_word(2'd1, 8'h44));
      expect_wb(2'd0, 8'h01);
      expect_wb(2'd0, 8'h02);
      expect_wb(2'd1, 8'h44);
      event_cycle = 60;
      wait_pos = 1;
    end
    // random immediates, trace from the testbench model
    3: build_random_program();
    // after another reset every register must read zero again
    default: begin
      put_word(addi_word(2'd0, 2'd0, 8'h01));
      put_word(addi_word(2'd1, 2'd1, 8'h02));
      put_word(addi_word(2'd2, 2'd2, 8'h03));
      put_word(addi_word(2'd3, 2'd3, 8'h04));
      expect_wb(2'd0, 8'h01);
      expect_wb(2'd1, 8'h02);
      expect_wb(2'd2, 8'h03);
      expect_wb(2'd3, 8'h04);
    end
  endcase
endtask

/* tests/tb_cce_top.sv */
// clock, reset, boot ROM model, program table loop, writeback checks and timeouts for cce_top
`timescale 1ns/1ps

module tb_cce_top;
  import cce_cfg_pkg::*;
  import cce_inst_pkg::*;

  logic clk = 1'b0;
  logic reset;
  logic ext_event;
  logic [inst_width_lp-1:0] boot_rom_data;
  logic [inst_addr_width_lp-1:0] boot_rom_addr;
  logic wb_v;
  logic [gpr_idx_width_lp-1:0] wb_idx;
  logic [gpr_width_lp-1:0] wb_data;

  // boot image of the program under test and its expected {index, value} trace
  logic [inst_width_lp-1:0] rom_mem [inst_ram_els_lp];
  logic [gpr_idx_width_lp+gpr_width_lp-1:0] exp_q [$];
  int word_cnt;
  int event_cycle;
  // trace entries from this position on must come after event_i rose
  int wait_pos;
  integer seed;

  // 4 ns period
  always #2 clk = ~clk;

  cce_top dut0 (
    .clk_i          (clk),
    .reset_i        (reset),
    .event_i        (ext_event),
    .boot_rom_data_i(boot_rom_data),
    .boot_rom_addr_o(boot_rom_addr),
    .wb_v_o         (wb_v),
    .wb_idx_o       (wb_idx),
    .wb_data_o      (wb_data)
  );

  // ROM answers the current address within the same cycle
  assign boot_rom_data = rom_mem[boot_rom_addr];

  // instruction encoders, opcode then payload as the formats lay it out
  function automatic logic [19:0] movi_word(input logic [1:0] dst, input logic [7:0] imm);
    return {OP_MOVI, dst, 2'b00, imm, 4'h0};
  endfunction

  function automatic logic [19:0] addi_word(input logic [1:0] dst, input logic [1:0] src,
                                            input logic [7:0] imm);
    return {OP_ADDI, dst, src, imm, 4'h0};
  endfunction

  function automatic logic [19:0] branch_word(input cce_op_e op, input logic [1:0] src_a,
                                              input logic [1:0] src_b, input logic [4:0] tgt);
    return {op, src_a, src_b, 7'h00, tgt};
  endfunction

  task automatic put_word(input logic [inst_width_lp-1:0] w);
    rom_mem[word_cnt] = w;
    word_cnt++;
  endtask

  task automatic expect_wb(input logic [1:0] idx, input logic [7:0] val);
    exp_q.push_back({idx, val});
  endtask

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // movi then a chain of dependent addi, expected values from a register model
  task automatic build_random_program();
    logic [7:0] model_gpr [4];
    logic [1:0] dst;
    int rnd;
    int i;
    for (i = 0; i < 4; i++) begin
      model_gpr[i] = 8'h00;
    end
    rnd = $random(seed);
    put_word(movi_word(2'd0, rnd[7:0]));
    model_gpr[0] = rnd[7:0];
    expect_wb(2'd0, model_gpr[0]);
    for (i = 1; i < 8; i++) begin
      rnd = $random(seed);
      dst = i[1:0];
      put_word(addi_word(dst, dst - 2'd1, rnd[7:0]));
      // 8 bit sum wraps modulo 256
      model_gpr[dst] = model_gpr[dst - 2'd1] + rnd[7:0];
      expect_wb(dst, model_gpr[dst]);
    end
  endtask

  `include "tb_cce_programs.svh"

  // reset held high for 8 rising edges, event_i dropped with it
  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    ext_event <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  endtask

  // cycle k counts edges since reset release, outputs sampled at the falling edge
  task automatic run_program();
    int k;
    int n;
    logic [1:0] e_idx;
    logic [7:0] e_data;
    logic [4:0] e_addr;
    k = 0;
    n = 0;
    while (k < 200 && exp_q.size() > 0) begin
      @(negedge clk);
      // one sweep 0..31, then parked at zero
      e_addr = (k < inst_ram_els_lp) ? k[4:0] : 5'd0;
      assert (boot_rom_addr == e_addr) else begin
        $display("mismatch boot_rom_addr_o: got 0x%0h expected 0x%0h", boot_rom_addr, e_addr);
        stop_with_failure();
      end
      if (wb_v) begin
        // first instruction shows at cycle 35, its writeback one cycle later
        assert (k > 35) else begin
          $display("writeback during boot, %0d cycles after reset release", k);
          stop_with_failure();
        end
        if (n >= wait_pos) begin
          assert (k > event_cycle) else begin
            $display("writeback past WAIT at cycle %0d before event_i rose", k);
            stop_with_failure();
          end
        end
        {e_idx, e_data} = exp_q.pop_front();
        assert (wb_idx == e_idx) else begin
          $display("mismatch wb_idx_o: got 0x%0h expected 0x%0h", wb_idx, e_idx);
          stop_with_failure();
        end
        assert (wb_data == e_data) else begin
          $display("mismatch wb_data_o: got 0x%02h expected 0x%02h", wb_data, e_data);
          stop_with_failure();
        end
        n++;
      end
      @(posedge clk);
      k++;
      if (k == event_cycle) begin
        ext_event <= 1'b1;
      end
    end
    assert (exp_q.size() == 0) else begin
      $display("timeout after 200 cycles with %0d writebacks still missing", exp_q.size());
      stop_with_failure();
    end
  endtask

  initial begin
    seed = 32'h71ceca92;
    reset = 1'b1;
    ext_event = 1'b0;
    for (int p = 0; p < num_progs_lp; p++) begin
      load_program(p);
      apply_reset();
      run_program();
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* hw/cce_top.sv */
// top level joining the PC unit, decoder and execute stage
`timescale 1ns/1ps

module cce_top (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       event_i,
  input  logic [cce_cfg_pkg::inst_width_lp-1:0]      boot_rom_data_i,
  output logic [cce_cfg_pkg::inst_addr_width_lp-1:0] boot_rom_addr_o,
  output logic                                       wb_v_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   wb_idx_o,
  output logic [cce_cfg_pkg::gpr_width_lp-1:0]       wb_data_o
);
  import cce_cfg_pkg::*;
  import cce_inst_pkg::*;

  // fetch to decode
  logic [inst_width_lp-1:0] inst;
  logic inst_v;

  // decode back to fetch, execute back to fetch
  logic pc_stall;
  logic [inst_addr_width_lp-1:0] branch_target;
  logic alu_branch_res;

  // decode to execute
  logic alu_we;
  logic alu_add;
  logic [gpr_idx_width_lp-1:0] alu_dst;
  logic [gpr_idx_width_lp-1:0] alu_src;
  logic [gpr_width_lp-1:0] alu_imm;
  cce_br_cond_e br_cond;
  logic [gpr_idx_width_lp-1:0] br_src_a;
  logic [gpr_idx_width_lp-1:0] br_src_b;

  cce_pc pc (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .alu_branch_res_i  (alu_branch_res),
    .pc_stall_i        (pc_stall),
    .pc_branch_target_i(branch_target),
    .boot_rom_data_i   (boot_rom_data_i),
    .inst_o            (inst),
    .inst_v_o          (inst_v),
    .boot_rom_addr_o   (boot_rom_addr_o)
  );

  cce_decode decode (
    .event_i           (event_i),
    .inst_i            (inst),
    .inst_v_i          (inst_v),
    .alu_we_o          (alu_we),
    .alu_add_o         (alu_add),
    .alu_dst_o         (alu_dst),
    .alu_src_o         (alu_src),
    .alu_imm_o         (alu_imm),
    .br_cond_o         (br_cond),
    .br_src_a_o        (br_src_a),
    .br_src_b_o        (br_src_b),
    .pc_branch_target_o(branch_target),
    .pc_stall_o        (pc_stall)
  );

  cce_exec exec (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .alu_we_i        (alu_we),
    .alu_add_i       (alu_add),
    .alu_dst_i       (alu_dst),
    .alu_src_i       (alu_src),
    .alu_imm_i       (alu_imm),
    .br_cond_i       (br_cond),
    .br_src_a_i      (br_src_a),
    .br_src_b_i      (br_src_b),
    .alu_branch_res_o(alu_branch_res),
    .wb_v_o          (wb_v_o),
    .wb_idx_o        (wb_idx_o),
    .wb_data_o       (wb_data_o)
  );

endmodule

/* hw/cce_exec.sv */
// general register file, move/add ALU, branch compare and registered writeback port
`timescale 1ns/1ps

module cce_exec (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     alu_we_i,
  input  logic                                     alu_add_i,
  input  logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] alu_dst_i,
  input  logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] alu_src_i,
  input  logic [cce_cfg_pkg::gpr_width_lp-1:0]     alu_imm_i,
  input  cce_inst_pkg::cce_br_cond_e               br_cond_i,
  input  logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] br_src_a_i,
  input  logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] br_src_b_i,
  output logic                                     alu_branch_res_o,
  output logic                                     wb_v_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] wb_idx_o,
  output logic [cce_cfg_pkg::gpr_width_lp-1:0]     wb_data_o
);
  import cce_cfg_pkg::*;
  import cce_inst_pkg::*;

  logic [gpr_width_lp-1:0] gpr_r [gpr_els_lp];
  logic [gpr_width_lp-1:0] alu_res;
  logic [gpr_width_lp-1:0] opd_a;
  logic [gpr_width_lp-1:0] opd_b;

  // add wraps at 8 bits
  assign alu_res = alu_add_i ? gpr_r[alu_src_i] + alu_imm_i : alu_imm_i;

  // branch operands read the current file, same cycle as the branch
  assign opd_a = gpr_r[br_src_a_i];
  assign opd_b = gpr_r[br_src_b_i];

  always_comb begin
    case (br_cond_i)
      BR_EQ:     alu_branch_res_o = (opd_a == opd_b);
      BR_NE:     alu_branch_res_o = (opd_a != opd_b);
      BR_ALWAYS: alu_branch_res_o = 1'b1;
      default:   alu_branch_res_o = 1'b0;
    endcase
  end

  // file and writeback strobe update on the same edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < gpr_els_lp; i++) begin
        gpr_r[i] <= '0;
      end
      wb_v_o <= 1'b0;
    end else begin
      if (alu_we_i) begin
        gpr_r[alu_dst_i] <= alu_res;
      end
      wb_v_o <= alu_we_i;
    end
  end

  // writeback payload, only meaningful with wb_v_o
  always_ff @(posedge clk_i) begin
    if (alu_we_i) begin
      wb_idx_o  <= alu_dst_i;
      wb_data_o <= alu_res;
    end
  end

endmodule

/* hw/cce_decode.sv */
// instruction decoder producing ALU controls, branch controls and the WAIT stall request
`timescale 1ns/1ps

module cce_decode (
  input  logic                                       event_i,
  input  logic [cce_cfg_pkg::inst_width_lp-1:0]      inst_i,
  input  logic                                       inst_v_i,
  output logic                                       alu_we_o,
  output logic                                       alu_add_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   alu_dst_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   alu_src_o,
  output logic [cce_cfg_pkg::gpr_width_lp-1:0]       alu_imm_o,
  output cce_inst_pkg::cce_br_cond_e                 br_cond_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   br_src_a_o,
  output logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   br_src_b_o,
  output logic [cce_cfg_pkg::inst_addr_width_lp-1:0] pc_branch_target_o,
  output logic                                       pc_stall_o
);
  import cce_inst_pkg::*;

  cce_inst_s inst;

  assign inst = inst_i;

  always_comb begin
    // operand fields pass straight from whichever view applies
    alu_dst_o          = inst.payload.alu.dst;
    alu_src_o          = inst.payload.alu.src;
    alu_imm_o          = inst.payload.alu.imm;
    br_src_a_o         = inst.payload.branch.src_a;
    br_src_b_o         = inst.payload.branch.src_b;
    pc_branch_target_o = inst.payload.branch.target;
    // controls idle unless a valid instruction asks for them
    alu_we_o   = 1'b0;
    alu_add_o  = 1'b0;
    br_cond_o  = BR_NONE;
    pc_stall_o = 1'b0;
    if (inst_v_i) begin
      case (inst.op)
        OP_MOVI: alu_we_o = 1'b1;
        OP_ADDI: begin
          alu_we_o  = 1'b1;
          alu_add_o = 1'b1;
        end
        OP_BEQ:  br_cond_o = BR_EQ;
        OP_BNE:  br_cond_o = BR_NE;
        OP_BI:   br_cond_o = BR_ALWAYS;
        // hold the PC until the event arrives
        OP_WAIT: pc_stall_o = !event_i;
        // NOP and undefined encodings
        default: alu_we_o = 1'b0;
      endcase
    end
  end

endmodule

/* hw/cce_pc.sv */
// PC state machine, boot ROM copy, next-PC steering and the instruction RAM instance
`timescale 1ns/1ps

module cce_pc (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       alu_branch_res_i,
  input  logic                                       pc_stall_i,
  input  logic [cce_cfg_pkg::inst_addr_width_lp-1:0] pc_branch_target_i,
  input  logic [cce_cfg_pkg::inst_width_lp-1:0]      boot_rom_data_i,
  output logic [cce_cfg_pkg::inst_width_lp-1:0]      inst_o,
  output logic                                       inst_v_o,
  output logic [cce_cfg_pkg::inst_addr_width_lp-1:0] boot_rom_addr_o
);
  import cce_cfg_pkg::*;

  typedef enum logic [1:0] {
    BOOT,
    BOOT_END,
    FETCH_START,
    FETCH
  } pc_state_e;

  pc_state_e pc_state_r, pc_state_n;

  // boot copy pointer and the two fetch-side PCs
  logic [inst_addr_width_lp-1:0] boot_rom_addr_r, boot_rom_addr_n;
  logic [inst_addr_width_lp-1:0] ex_pc_r, ex_pc_n;
  logic [inst_addr_width_lp-1:0] ram_addr_r, ram_addr_n;
  logic inst_v_r, inst_v_n;

  // registered RAM controls, address is steered combinationally in FETCH
  logic ram_v_r, ram_v_n;
  logic ram_w_r, ram_w_n;
  logic [inst_addr_width_lp-1:0] ram_addr;
  logic [inst_width_lp-1:0] ram_data_r;
  logic [inst_width_lp-1:0] ram_data;

  cce_inst_ram inst_ram (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (ram_v_r),
    .w_i    (ram_w_r),
    .addr_i (ram_addr),
    .data_i (ram_data_r),
    .data_o (ram_data)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_state_r      <= BOOT;
      boot_rom_addr_r <= '0;
      ex_pc_r         <= '0;
      ram_addr_r      <= '0;
      inst_v_r        <= 1'b0;
      ram_v_r         <= 1'b0;
      ram_w_r         <= 1'b0;
    end else begin
      pc_state_r      <= pc_state_n;
      boot_rom_addr_r <= boot_rom_addr_n;
      ex_pc_r         <= ex_pc_n;
      ram_addr_r      <= ram_addr_n;
      inst_v_r        <= inst_v_n;
      ram_v_r         <= ram_v_n;
      ram_w_r         <= ram_w_n;
    end
  end

  // rom word lands in RAM one cycle after its address goes out
  always_ff @(posedge clk_i) begin
    ram_data_r <= boot_rom_data_i;
  end

  always_comb begin
    boot_rom_addr_o = boot_rom_addr_r;
    inst_v_o        = inst_v_r;
    inst_o          = ram_data;
    // defaults, overridden per state
    ram_addr        = ram_addr_r;
    pc_state_n      = pc_state_r;
    boot_rom_addr_n = '0;
    ex_pc_n         = '0;
    ram_addr_n      = ram_addr_r;
    inst_v_n        = 1'b0;
    ram_v_n         = 1'b1;
    ram_w_n         = 1'b0;
    case (pc_state_r)
      BOOT: begin
        // write word k at the edge after rom address k
        ram_w_n         = 1'b1;
        ram_addr_n      = boot_rom_addr_r;
        boot_rom_addr_n = boot_rom_addr_r + 1'b1;
        if (boot_rom_addr_r == inst_addr_width_lp'(inst_ram_els_lp - 1)) begin
          pc_state_n = BOOT_END;
        end
      end
      BOOT_END: begin
        // last boot write retires this cycle, aim the fetch pointer at 0
        ram_addr_n = '0;
        pc_state_n = FETCH_START;
      end
      FETCH_START: begin
        // warm-up read of word 0, the pointer stays so FETCH issues 0 again
        ram_addr_n = '0;
        pc_state_n = FETCH;
      end
      FETCH: begin
        inst_v_n = 1'b1;
        if (pc_stall_i) begin
          // re-read the executing instruction
          ram_addr = ex_pc_r;
          ex_pc_n  = ex_pc_r;
        end else if (alu_branch_res_i) begin
          // target is presented next cycle, no bubble
          ram_addr   = pc_branch_target_i;
          ex_pc_n    = pc_branch_target_i;
          ram_addr_n = pc_branch_target_i + 1'b1;
        end else begin
          ex_pc_n    = ram_addr_r;
          ram_addr_n = ram_addr_r + 1'b1;
        end
      end
      default: begin
        pc_state_n = BOOT;
        ram_v_n    = 1'b0;
      end
    endcase
  end

  // no instruction leaves the unit until the FSM reaches steady fetch
  a_no_inst_in_boot: assert property (@(posedge clk_i) disable iff (reset_i)
    (pc_state_r != FETCH) |-> !inst_v_o);

  // rom address is parked at zero once the copy is done
  a_rom_addr_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    (pc_state_r != BOOT) |-> (boot_rom_addr_o == '0));

endmodule

/* hw/cce_inst_ram.sv */
// single-port synchronous instruction RAM with registered read data
`timescale 1ns/1ps

module cce_inst_ram (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   v_i,
  input  logic                                   w_i,
  input  logic [cce_cfg_pkg::inst_addr_width_lp-1:0] addr_i,
  input  logic [cce_cfg_pkg::inst_width_lp-1:0]  data_i,
  output logic [cce_cfg_pkg::inst_width_lp-1:0]  data_o
);
  import cce_cfg_pkg::*;

  logic [inst_width_lp-1:0] mem_r [inst_ram_els_lp];

  // one access per cycle, a write leaves data_o untouched
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem_r[addr_i] <= data_i;
      end else begin
        data_o <= mem_r[addr_i];
      end
    end
  end

  // the PC unit must never present an X address or X write enable with a valid access
  a_known_access: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> !$isunknown({w_i, addr_i}));

endmodule

/* hw/cce_inst_pkg.sv */
// opcode enum, branch condition enum, ALU and branch payload formats, instruction union
package cce_inst_pkg;

  // opcode sits in the top bits of every instruction
  localparam int op_width_lp = 4;
  localparam int payload_width_lp = cce_cfg_pkg::inst_width_lp - op_width_lp;

  // padding needed to square each format up to the payload width
  localparam int alu_pad_width_lp =
    payload_width_lp - 2 * cce_cfg_pkg::gpr_idx_width_lp - cce_cfg_pkg::gpr_width_lp;
  localparam int branch_pad_width_lp =
    payload_width_lp - 2 * cce_cfg_pkg::gpr_idx_width_lp - cce_cfg_pkg::inst_addr_width_lp;

  // encodings 7 and up are undefined and execute as NOP
  typedef enum logic [op_width_lp-1:0] {
    OP_NOP  = 4'd0,
    OP_MOVI = 4'd1,
    OP_ADDI = 4'd2,
    OP_BEQ  = 4'd3,
    OP_BNE  = 4'd4,
    OP_BI   = 4'd5,
    OP_WAIT = 4'd6
  } cce_op_e;

  // branch condition handed from decode to execute
  typedef enum logic [1:0] {
    BR_EQ     = 2'd0,
    BR_NE     = 2'd1,
    BR_ALWAYS = 2'd2,
    BR_NONE   = 2'd3
  } cce_br_cond_e;

  // MOVI and ADDI view of the payload
  typedef struct packed {
    logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] dst;
    logic [cce_cfg_pkg::gpr_idx_width_lp-1:0] src;
    logic [cce_cfg_pkg::gpr_width_lp-1:0]     imm;
    logic [alu_pad_width_lp-1:0]              pad;
  } cce_alu_fmt_s;

  // BEQ, BNE and BI view, target in the low bits
  typedef struct packed {
    logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   src_a;
    logic [cce_cfg_pkg::gpr_idx_width_lp-1:0]   src_b;
    logic [branch_pad_width_lp-1:0]             pad;
    logic [cce_cfg_pkg::inst_addr_width_lp-1:0] target;
  } cce_branch_fmt_s;

  // same 16 payload bits, decoded per opcode
  typedef union packed {
    cce_alu_fmt_s    alu;
    cce_branch_fmt_s branch;
  } cce_payload_u;

  typedef struct packed {
    cce_op_e      op;
    cce_payload_u payload;
  } cce_inst_s;

endpackage

/* hw/cce_cfg_pkg.sv */
// sizing constants for the instruction RAM, instruction word and general registers
package cce_cfg_pkg;

  // instruction RAM depth in words
  localparam int inst_ram_els_lp = 32;

  // address into the instruction RAM, also the width of the PC
  localparam int inst_addr_width_lp = $clog2(inst_ram_els_lp);

  // full instruction word, 4 bit opcode plus 16 bit payload
  localparam int inst_width_lp = 20;

  // general purpose register file
  localparam int gpr_els_lp = 4;

  // index into the register file
  localparam int gpr_idx_width_lp = $clog2(gpr_els_lp);

  // each register holds one byte
  localparam int gpr_width_lp = 8;

endpackage
